/* source/exeDown_consts.svh */
`ifndef EXEDOWN_CONSTS_SVH
`define EXEDOWN_CONSTS_SVH

//////////////////////////////
// datapath widths
//////////////////////////////
`define EXE_WORD_W 32   // one machine word
`define EXE_GPR_W 5     // register number

//////////////////////////////
// leading-count unit
//////////////////////////////
`define EXE_CL_W 6      // wide enough to hold 32
`define EXE_CL_START 31 // top bit of the word, scanned first

`endif

/* source/exeDownPkg.sv */
`include "exeDown_consts.svh"

package exeDownPkg;

    //////////////////////////////
    // opcodes and selectors
    //////////////////////////////
    typedef enum logic [3:0] {
        aluAdd, aluAddu, aluSub, aluSubu,
        aluAnd, aluOr, aluXor, aluNor,
        aluSlt, aluSltu, aluSll, aluSrl,
        aluSra, aluLui, aluClo, aluClz
    } aluOp_e;

    // where each operand comes from
    typedef enum logic [1:0] {
        regData, fwdExe, fwdMem, imm
    } fwdSel_e;

    typedef enum logic [3:0] {
        memNone, memLb, memLbu, memLh, memLhu, memLw, memSb, memSh, memSw
    } memOp_e;

    typedef enum logic [2:0] {
        trapNone, trapEq, trapNe, trapLt, trapGe
    } trapKind_e;

    typedef enum logic [2:0] {
        excNone, excOv, excTr, excAdel, excAdes, excExt
    } excCode_e;

    //////////////////////////////
    // bundles
    //////////////////////////////
    typedef struct packed {
        logic [`EXE_WORD_W-1:0] exeRes; // result leaving the execute stage
        logic [`EXE_WORD_W-1:0] memRes; // result leaving the memory stage
    } fwdBus_t;

    typedef struct packed {
        logic [`EXE_GPR_W-1:0]  writeNum;  // 0 means no write-back
        logic [`EXE_WORD_W-1:0] regData0;
        logic [`EXE_WORD_W-1:0] regData1;  // also the store data source
        logic [`EXE_WORD_W-1:0] imm;
        fwdSel_e                sel0;
        fwdSel_e                sel1;
        aluOp_e                 aluOp;
        memOp_e                 memOp;
        trapKind_e              trapKind;
        logic                   ovEnable;  // add/sub that may raise ov
        logic                   hasExc;    // exception found in decode
        excCode_e               excCode;
        logic [`EXE_WORD_W-1:0] pc;
    } exeReq_t;

    typedef struct packed {
        logic [`EXE_GPR_W-1:0]  writeNum;
        logic [`EXE_WORD_W-1:0] result;
        logic                   memReq;
        logic                   memWrite;
        logic [3:0]             byteEn;
        logic [`EXE_WORD_W-1:0] storeData;
        logic                   hasExc;
        excCode_e               excCode;
        logic [`EXE_WORD_W-1:0] badVAddr;
        logic [`EXE_WORD_W-1:0] pc;
    } exeRes_t;

endpackage

/* source/stageReg.sv */
module stageReg (
    input  logic                clk,
    input  logic                rst,
    input  logic                reqValid_i,
    input  exeDownPkg::exeReq_t req_i,
    input  exeDownPkg::fwdBus_t fwd_i,
    input  logic                downAllowin_i,
    input  logic                flush_i,
    input  logic                ready_i,
    output logic                allowin_o,
    output logic                hasData_o,
    output exeDownPkg::exeReq_t heldReq_o,
    output exeDownPkg::fwdBus_t heldFwd_o,
    output logic                load_o
);

    logic capture;
    logic clear;

    //////////////////////////////
    // interlock
    //////////////////////////////
    // room when empty, or when the held op finishes this cycle
    assign allowin_o = downAllowin_i && (!hasData_o || ready_i);
    assign capture   = allowin_o && reqValid_i && !flush_i;
    // old op leaves with nothing new behind it
    assign clear     = flush_i || (allowin_o && !reqValid_i);

    always_ff @(posedge clk) begin
        if (!rst || clear) begin
            hasData_o <= 1'b0;
        end else if (capture) begin
            hasData_o <= 1'b1;
        end
    end

    //////////////////////////////
    // held instruction
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst || clear) begin
            heldReq_o <= '0;
            heldFwd_o <= '0;
        end else if (capture) begin
            heldReq_o <= req_i;
            heldFwd_o <= fwd_i; // forwarded words sampled with the request
        end
    end

    // one-cycle pulse after capture, kicks off the CL counter
    always_ff @(posedge clk) begin
        if (!rst) begin
            load_o <= 1'b0;
        end else begin
            load_o <= capture;
        end
    end

    // a flush leaves the stage empty and starts no counter
    flushEmpties: assert property (
        @(posedge clk) disable iff (!rst)
        flush_i |=> !hasData_o && !load_o
    );

endmodule

/* source/operandForward.sv */
`include "exeDown_consts.svh"

module operandForward (
    input  exeDownPkg::exeReq_t     heldReq_i,
    input  exeDownPkg::fwdBus_t     heldFwd_i,
    output logic [`EXE_WORD_W-1:0]  src0_o,
    output logic [`EXE_WORD_W-1:0]  src1_o
);

    // one mux, shared by both operands
    function automatic logic [`EXE_WORD_W-1:0] pickSrc(
        input exeDownPkg::fwdSel_e    sel,
        input logic [`EXE_WORD_W-1:0] regWord
    );
        logic [`EXE_WORD_W-1:0] picked;
        unique case (sel)
            exeDownPkg::regData: picked = regWord;
            exeDownPkg::fwdExe:  picked = heldFwd_i.exeRes;
            exeDownPkg::fwdMem:  picked = heldFwd_i.memRes;
            exeDownPkg::imm:     picked = heldReq_i.imm;
            default:             picked = regWord;
        endcase
        return picked;
    endfunction

    always_comb begin
        src0_o = pickSrc(heldReq_i.sel0, heldReq_i.regData0);
        src1_o = pickSrc(heldReq_i.sel1, heldReq_i.regData1);
    end

endmodule

/* source/execAlu.sv */
`include "exeDown_consts.svh"

module execAlu (
    input  logic [`EXE_WORD_W-1:0] src0_i,
    input  logic [`EXE_WORD_W-1:0] src1_i,
    input  exeDownPkg::aluOp_e     aluOp_i,
    input  exeDownPkg::trapKind_e  trapKind_i,
    output logic [`EXE_WORD_W-1:0] aluRes_o,
    output logic                   overflow_o,
    output logic                   trap_o
);

    localparam int Msb = `EXE_WORD_W - 1;

    logic [`EXE_WORD_W-1:0] addRes;
    logic [`EXE_WORD_W-1:0] subRes;
    logic [4:0]             shamt;
    logic                   addOv;
    logic                   subOv;
    logic                   isZero;

    assign addRes = src0_i + src1_i;
    assign subRes = src0_i - src1_i;
    assign shamt  = src0_i[4:0]; // shifts move src1 by src0

    // same-sign inputs, different-sign sum
    assign addOv = (src0_i[Msb] == src1_i[Msb]) && (addRes[Msb] != src0_i[Msb]);
    assign subOv = (src0_i[Msb] != src1_i[Msb]) && (subRes[Msb] != src0_i[Msb]);

    always_comb begin
        unique case (aluOp_i)
            exeDownPkg::aluAdd, exeDownPkg::aluAddu: aluRes_o = addRes;
            exeDownPkg::aluSub, exeDownPkg::aluSubu: aluRes_o = subRes;
            exeDownPkg::aluAnd:  aluRes_o = src0_i & src1_i;
            exeDownPkg::aluOr:   aluRes_o = src0_i | src1_i;
            exeDownPkg::aluXor:  aluRes_o = src0_i ^ src1_i;
            exeDownPkg::aluNor:  aluRes_o = ~(src0_i | src1_i);
            exeDownPkg::aluSlt:  aluRes_o = {{Msb{1'b0}}, $signed(src0_i) < $signed(src1_i)};
            exeDownPkg::aluSltu: aluRes_o = {{Msb{1'b0}}, src0_i < src1_i};
            exeDownPkg::aluSll:  aluRes_o = src1_i << shamt;
            exeDownPkg::aluSrl:  aluRes_o = src1_i >> shamt;
            exeDownPkg::aluSra:  aluRes_o = $signed(src1_i) >>> shamt;
            exeDownPkg::aluLui:  aluRes_o = {src1_i[15:0], 16'h0000};
            default:             aluRes_o = '0; // clo/clz come from the counter
        endcase
    end

    assign overflow_o = (aluOp_i == exeDownPkg::aluAdd && addOv) ||
                        (aluOp_i == exeDownPkg::aluSub && subOv);

    //////////////////////////////
    // trap condition
    //////////////////////////////
    assign isZero = (aluRes_o == '0); // eq/ne ride on a sub

    always_comb begin
        unique case (trapKind_i)
            exeDownPkg::trapEq: trap_o = isZero;
            exeDownPkg::trapNe: trap_o = !isZero;
            exeDownPkg::trapLt: trap_o = aluRes_o[0]; // slt/sltu result
            exeDownPkg::trapGe: trap_o = !aluRes_o[0];
            default:            trap_o = 1'b0;
        endcase
    end

endmodule

/* source/memAlign.sv */
`include "exeDown_consts.svh"

module memAlign (
    input  logic [`EXE_WORD_W-1:0] addr_i,
    input  logic [`EXE_WORD_W-1:0] storeSrc_i,
    input  exeDownPkg::memOp_e     memOp_i,
    output logic [3:0]             byteEn_o,
    output logic [`EXE_WORD_W-1:0] storeData_o,
    output logic                   misalign_o,
    output logic                   isStore_o
);

    logic [1:0] offset;
    logic [3:0] byteLane;
    logic [3:0] halfLane;
    logic       halfOdd;
    logic       wordOff;

    //////////////////////////////
    // lane decode
    //////////////////////////////
    assign offset   = addr_i[1:0];
    assign byteLane = 4'b0001 << offset;
    assign halfLane = offset[1] ? 4'b1100 : 4'b0011;
    assign halfOdd  = offset[0];
    assign wordOff  = |offset;

    always_comb begin
        byteEn_o    = 4'b0000;
        storeData_o = '0; // only stores drive data
        misalign_o  = 1'b0;
        isStore_o   = 1'b0;
        unique case (memOp_i)
            exeDownPkg::memLb, exeDownPkg::memLbu: begin
                byteEn_o = byteLane;
            end
            exeDownPkg::memLh, exeDownPkg::memLhu: begin
                byteEn_o   = halfLane;
                misalign_o = halfOdd;
            end
            exeDownPkg::memLw: begin
                byteEn_o   = 4'b1111;
                misalign_o = wordOff;
            end
            exeDownPkg::memSb: begin
                byteEn_o    = byteLane;
                storeData_o = {4{storeSrc_i[7:0]}}; // every lane sees the byte
                isStore_o   = 1'b1;
            end
            exeDownPkg::memSh: begin
                byteEn_o    = halfLane;
                storeData_o = {2{storeSrc_i[15:0]}};
                misalign_o  = halfOdd;
                isStore_o   = 1'b1;
            end
            exeDownPkg::memSw: begin
                byteEn_o    = 4'b1111;
                storeData_o = storeSrc_i;
                misalign_o  = wordOff;
                isStore_o   = 1'b1;
            end
            default: begin
                byteEn_o = 4'b0000; // no access
            end
        endcase
    end

endmodule

/* source/countLeading.sv */
`include "exeDown_consts.svh"

module countLeading (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_i,
    input  logic                   flush_i,
    input  logic                   countOnes_i,
    input  logic [`EXE_WORD_W-1:0] src_i,
    output logic [`EXE_CL_W-1:0]   count_o,
    output logic                   done_o
);

    localparam int PosW = $clog2(`EXE_WORD_W);

    logic [PosW-1:0] pos;
    logic            busy;
    logic            matching; // still inside the leading run
    logic            hiHit;
    logic            loHit;

    assign hiHit = (src_i[pos] == countOnes_i);
    assign loHit = (src_i[pos - 1'b1] == countOnes_i);

    // two bits per step, 16 steps per word
    always_ff @(posedge clk) begin
        if (!rst || flush_i) begin
            busy     <= 1'b0;
            done_o   <= 1'b0;
            matching <= 1'b0;
            count_o  <= '0;
            pos      <= PosW'(`EXE_CL_START);
        end else if (start_i) begin
            busy     <= 1'b1;
            done_o   <= 1'b0;
            matching <= 1'b1;
            count_o  <= '0;
            pos      <= PosW'(`EXE_CL_START);
        end else if (busy) begin
            if (matching) begin
                if (hiHit && loHit) begin
                    count_o <= count_o + 2'd2;
                end else begin
                    count_o  <= count_o + {{(`EXE_CL_W-1){1'b0}}, hiHit};
                    matching <= 1'b0; // run ended in this pair
                end
            end
            pos <= pos - 2'd2;
            if (pos == PosW'(1)) begin
                busy   <= 1'b0;
                done_o <= 1'b1;
            end
        end
    end

    // an all-matching word stops at exactly 32
    countBound: assert property (
        @(posedge clk) disable iff (!rst)
        count_o <= `EXE_CL_W'(`EXE_WORD_W)
    );

endmodule

/* source/exeDown.sv */
`include "exeDown_consts.svh"

module exeDown (
    input  logic                clk,
    input  logic                rst,
    input  logic                reqValid_i,
    input  exeDownPkg::exeReq_t req_i,
    input  exeDownPkg::fwdBus_t fwd_i,
    input  logic                downAllowin_i,
    input  logic                flush_i,
    output logic                allowin_o,
    output logic                resValid_o,
    output exeDownPkg::exeRes_t res_o
);

    exeDownPkg::exeReq_t    heldReq;
    exeDownPkg::fwdBus_t    heldFwd;
    logic                   hasData;
    logic                   load;
    logic                   ready;
    logic [`EXE_WORD_W-1:0] src0;
    logic [`EXE_WORD_W-1:0] src1;
    logic [`EXE_WORD_W-1:0] aluRes;
    logic                   overflow;
    logic                   trap;
    logic [3:0]             byteEn;
    logic [`EXE_WORD_W-1:0] storeData;
    logic                   misalign;
    logic                   isStore;
    logic [`EXE_CL_W-1:0]   clCount;
    logic                   clDone;
    logic                   isCl;

    stageReg uStageReg (
        .clk(clk), .rst(rst),
        .reqValid_i(reqValid_i), .req_i(req_i), .fwd_i(fwd_i),
        .downAllowin_i(downAllowin_i), .flush_i(flush_i), .ready_i(ready),
        .allowin_o(allowin_o), .hasData_o(hasData),
        .heldReq_o(heldReq), .heldFwd_o(heldFwd), .load_o(load)
    );

    operandForward uOperandForward (
        .heldReq_i(heldReq), .heldFwd_i(heldFwd), .src0_o(src0), .src1_o(src1)
    );

    execAlu uExecAlu (
        .src0_i(src0), .src1_i(src1),
        .aluOp_i(heldReq.aluOp), .trapKind_i(heldReq.trapKind),
        .aluRes_o(aluRes), .overflow_o(overflow), .trap_o(trap)
    );

    // store data is the register word of operand 1
    memAlign uMemAlign (
        .addr_i(aluRes), .storeSrc_i(heldReq.regData1), .memOp_i(heldReq.memOp),
        .byteEn_o(byteEn), .storeData_o(storeData),
        .misalign_o(misalign), .isStore_o(isStore)
    );

    countLeading uCountLeading (
        .clk(clk), .rst(rst), .start_i(load && isCl), .flush_i(flush_i),
        .countOnes_i(heldReq.aluOp == exeDownPkg::aluClo), .src_i(src0),
        .count_o(clCount), .done_o(clDone)
    );

    //////////////////////////////
    // readiness and handoff
    //////////////////////////////
    assign isCl  = (heldReq.aluOp == exeDownPkg::aluClo) ||
                   (heldReq.aluOp == exeDownPkg::aluClz);
    // done from the previous count is stale while the new one starts
    assign ready = !isCl || (clDone && !load);
    // flushed op never leaves the stage
    assign resValid_o = hasData && ready && downAllowin_i && !flush_i;

    //////////////////////////////
    // result and exceptions
    //////////////////////////////
    always_comb begin
        res_o.writeNum  = heldReq.writeNum;
        res_o.result    = isCl ? {{(`EXE_WORD_W-`EXE_CL_W){1'b0}}, clCount} : aluRes;
        res_o.memReq    = (heldReq.memOp != exeDownPkg::memNone);
        res_o.memWrite  = isStore;
        res_o.byteEn    = byteEn;
        res_o.storeData = storeData;
        res_o.pc        = heldReq.pc;
        res_o.hasExc    = 1'b1;
        res_o.badVAddr  = aluRes; // faulting data address
        if (heldReq.hasExc) begin
            res_o.excCode  = heldReq.excCode; // decode wins
            res_o.badVAddr = heldReq.pc;
        end else if (heldReq.ovEnable && overflow) begin
            res_o.excCode = exeDownPkg::excOv;
        end else if (trap) begin
            res_o.excCode = exeDownPkg::excTr;
        end else if (misalign) begin
            res_o.excCode = isStore ? exeDownPkg::excAdes : exeDownPkg::excAdel;
        end else begin
            res_o.hasExc  = 1'b0;
            res_o.excCode = exeDownPkg::excNone;
        end
    end

    // a result leaving with nothing behind it empties the stage
    resultLeavesOnce: assert property (
        @(posedge clk) disable iff (!rst)
        resValid_o && !reqValid_i |=> !hasData
    );

    // a finished op waiting on the next stage keeps its result
    stallHoldsRes: assert property (
        @(posedge clk) disable iff (!rst)
        hasData && ready && !downAllowin_i && !flush_i |=> $stable(res_o)
    );

endmodule

/* dv/exeDownChecker.sv */
`include "exeDown_consts.svh"

module exeDownChecker (
    input  logic                clk,
    input  logic                rst,
    input  logic                reqValid_i,
    input  exeDownPkg::exeReq_t req_i,
    input  exeDownPkg::fwdBus_t fwd_i,
    input  logic                downAllowin_i,
    input  logic                flush_i,
    input  logic                allowin_i,
    input  logic                resValid_i,
    input  exeDownPkg::exeRes_t res_i,
    output int                  valueErrs_o,
    output int                  otherErrs_o,
    output int                  pending_o,
    output int                  checked_o
);

    localparam int BaseLatency = 1;
    localparam int ClLatency   = 18; // counter start, 16 steps, then hand-off

    typedef struct packed {
        exeDownPkg::exeReq_t req;
        exeDownPkg::fwdBus_t fwd;
        logic [31:0]         acceptCyc;
    } heldEntry_t;

    heldEntry_t  pendQ[$];
    logic [31:0] cyc;
    logic        stallSeen; // head waited on a low downAllowin_i
    int          valueErrs = 0;
    int          otherErrs = 0;
    int          checked = 0;

    assign valueErrs_o = valueErrs;
    assign otherErrs_o = otherErrs;
    assign pending_o   = pendQ.size();
    assign checked_o   = checked;

    //////////////////////////////
    // reference model
    //////////////////////////////
    function automatic logic [`EXE_WORD_W-1:0] chooseOperand(
        input exeDownPkg::fwdSel_e    sel,
        input logic [`EXE_WORD_W-1:0] regWord,
        input logic [`EXE_WORD_W-1:0] immWord,
        input exeDownPkg::fwdBus_t    fw
    );
        case (sel)
            exeDownPkg::fwdExe: return fw.exeRes;
            exeDownPkg::fwdMem: return fw.memRes;
            exeDownPkg::imm:    return immWord;
            default:            return regWord;
        endcase
    endfunction

    // length of the leading run of ones or zeros
    function automatic logic [`EXE_WORD_W-1:0] leadingCount(
        input logic [`EXE_WORD_W-1:0] w,
        input logic                   ones
    );
        int  n;
        logic run;
        n = 0;
        run = 1'b1;
        for (int i = `EXE_WORD_W - 1; i >= 0; i--) begin
            if (run && w[i] == ones) begin
                n++;
            end else begin
                run = 1'b0;
            end
        end
        return n;
    endfunction

    function automatic exeDownPkg::exeRes_t expectRes(
        input exeDownPkg::exeReq_t rq,
        input exeDownPkg::fwdBus_t fw
    );
        exeDownPkg::exeRes_t    r;
        logic [`EXE_WORD_W-1:0] a;
        logic [`EXE_WORD_W-1:0] b;
        logic [`EXE_WORD_W-1:0] alu;
        logic [`EXE_WORD_W:0]   wide;
        logic [1:0]             off;
        logic                   ov;
        logic                   tr;
        logic                   mis;
        a = chooseOperand(rq.sel0, rq.regData0, rq.imm, fw);
        b = chooseOperand(rq.sel1, rq.regData1, rq.imm, fw);
        ov = 1'b0;
        case (rq.aluOp)
            exeDownPkg::aluAdd, exeDownPkg::aluAddu: alu = a + b;
            exeDownPkg::aluSub, exeDownPkg::aluSubu: alu = a - b;
            exeDownPkg::aluAnd:  alu = a & b;
            exeDownPkg::aluOr:   alu = a | b;
            exeDownPkg::aluXor:  alu = a ^ b;
            exeDownPkg::aluNor:  alu = ~(a | b);
            exeDownPkg::aluSlt:  alu = ($signed(a) < $signed(b)) ? 1 : 0;
            exeDownPkg::aluSltu: alu = (a < b) ? 1 : 0;
            exeDownPkg::aluSll:  alu = b << a[4:0];
            exeDownPkg::aluSrl:  alu = b >> a[4:0];
            exeDownPkg::aluSra:  alu = $unsigned($signed(b) >>> a[4:0]);
            exeDownPkg::aluLui:  alu = {b[15:0], 16'h0000};
            exeDownPkg::aluClo:  alu = leadingCount(a, 1'b1);
            default:             alu = leadingCount(a, 1'b0);
        endcase
        if (rq.aluOp == exeDownPkg::aluAdd) begin
            wide = {a[`EXE_WORD_W-1], a} + {b[`EXE_WORD_W-1], b};
            ov = wide[`EXE_WORD_W] ^ wide[`EXE_WORD_W-1];
        end else if (rq.aluOp == exeDownPkg::aluSub) begin
            wide = {a[`EXE_WORD_W-1], a} - {b[`EXE_WORD_W-1], b};
            ov = wide[`EXE_WORD_W] ^ wide[`EXE_WORD_W-1];
        end
        case (rq.trapKind)
            exeDownPkg::trapEq: tr = (alu == 0);
            exeDownPkg::trapNe: tr = (alu != 0);
            exeDownPkg::trapLt: tr = alu[0];
            exeDownPkg::trapGe: tr = !alu[0];
            default:            tr = 1'b0;
        endcase
        // lanes from the low address bits
        off = alu[1:0];
        r = '0;
        mis = 1'b0;
        case (rq.memOp)
            exeDownPkg::memLb, exeDownPkg::memLbu, exeDownPkg::memSb: begin
                r.byteEn = 4'b0001 << off;
            end
            exeDownPkg::memLh, exeDownPkg::memLhu, exeDownPkg::memSh: begin
                r.byteEn = off[1] ? 4'b1100 : 4'b0011;
                mis = off[0];
            end
            exeDownPkg::memLw, exeDownPkg::memSw: begin
                r.byteEn = 4'b1111;
                mis = (off != 2'b00);
            end
            default: r.byteEn = 4'b0000;
        endcase
        r.memWrite = (rq.memOp == exeDownPkg::memSb) || (rq.memOp == exeDownPkg::memSh) ||
                     (rq.memOp == exeDownPkg::memSw);
        case (rq.memOp)
            exeDownPkg::memSb: r.storeData = {4{rq.regData1[7:0]}};
            exeDownPkg::memSh: r.storeData = {2{rq.regData1[15:0]}};
            default:           r.storeData = rq.regData1;
        endcase
        r.writeNum = rq.writeNum;
        r.result   = alu;
        r.memReq   = (rq.memOp != exeDownPkg::memNone);
        r.pc       = rq.pc;
        r.hasExc   = 1'b1;
        r.badVAddr = alu;
        if (rq.hasExc) begin
            r.excCode  = rq.excCode;
            r.badVAddr = rq.pc;
        end else if (rq.ovEnable && ov) begin
            r.excCode = exeDownPkg::excOv;
        end else if (tr) begin
            r.excCode = exeDownPkg::excTr;
        end else if (mis) begin
            r.excCode = r.memWrite ? exeDownPkg::excAdes : exeDownPkg::excAdel;
        end else begin
            r.hasExc  = 1'b0;
            r.excCode = exeDownPkg::excNone;
        end
        return r;
    endfunction

    //////////////////////////////
    // comparison
    //////////////////////////////
    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        if (got !== want) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, want);
            valueErrs++;
        end
    endtask

    task automatic compareRes(input exeDownPkg::exeRes_t got, input exeDownPkg::exeRes_t want);
        compareField("res_o.writeNum", 32'(got.writeNum), 32'(want.writeNum));
        compareField("res_o.result", got.result, want.result);
        compareField("res_o.memReq", 32'(got.memReq), 32'(want.memReq));
        compareField("res_o.memWrite", 32'(got.memWrite), 32'(want.memWrite));
        compareField("res_o.byteEn", 32'(got.byteEn), 32'(want.byteEn));
        compareField("res_o.hasExc", 32'(got.hasExc), 32'(want.hasExc));
        compareField("res_o.excCode", 32'(got.excCode), 32'(want.excCode));
        compareField("res_o.pc", got.pc, want.pc);
        if (want.memWrite) begin
            compareField("res_o.storeData", got.storeData, want.storeData);
        end
        if (want.hasExc) begin
            compareField("res_o.badVAddr", got.badVAddr, want.badVAddr);
        end
    endtask

    always @(posedge clk) begin : watch
        heldEntry_t          head;
        heldEntry_t          entry;
        exeDownPkg::exeRes_t want;
        logic                headCl;
        logic [31:0]         lat;
        int                  wantLat;
        if (!rst) begin
            pendQ.delete();
            cyc = '0;
            stallSeen = 1'b0;
        end else begin
            cyc = cyc + 1;
            if (flush_i) begin
                pendQ.delete(); // flushed op must never show up
            end else begin
                if (pendQ.size() != 0) begin
                    head = pendQ[0];
                    want = expectRes(head.req, head.fwd);
                    headCl = (head.req.aluOp == exeDownPkg::aluClo) ||
                             (head.req.aluOp == exeDownPkg::aluClz);
                    lat = cyc - head.acceptCyc;
                    wantLat = headCl ? ClLatency : BaseLatency;
                    // the counter runs on, only a stall once it is done delays the result
                    if (!downAllowin_i && lat >= wantLat) begin
                        stallSeen = 1'b1;
                    end
                    if (resValid_i) begin
                        compareRes(res_i, want);
                        if (lat < wantLat || (!stallSeen && lat != wantLat)) begin
                            $display("latency wrong at %0t: op at pc %h took %0d cycles, not %0d",
                                     $time, head.req.pc, lat, wantLat);
                            otherErrs++;
                        end
                        void'(pendQ.pop_front());
                        checked++;
                    end else if (!headCl && !downAllowin_i) begin
                        compareRes(res_i, want); // held steady during the stall
                    end
                end else if (resValid_i) begin
                    $display("result handed on at %0t with no request in the stage", $time);
                    otherErrs++;
                end
                if (reqValid_i && allowin_i) begin
                    if (pendQ.size() != 0) begin
                        $display("second request accepted at %0t while the stage was busy",
                                 $time);
                        otherErrs++;
                    end
                    entry.req = req_i;
                    entry.fwd = fwd_i;
                    entry.acceptCyc = cyc;
                    pendQ.push_back(entry);
                    stallSeen = 1'b0;
                end
            end
        end
    end

endmodule

/* dv/exeDownTb.sv */
module exeDownTb;

    localparam int NumReqs    = 400;
    localparam int CycleLimit = NumReqs * 20;

    logic                clk;
    logic                rst;
    logic                reqValid;
    logic                downAllowin;
    logic                flush;
    logic                allowin;
    logic                resValid;
    logic                taken;
    exeDownPkg::exeReq_t req;
    exeDownPkg::fwdBus_t fwd;
    exeDownPkg::exeRes_t res;
    logic [31:0]         lfsr;
    logic [31:0]         v;
    int                  accepted;
    int                  cycles = 0;
    int                  valueErrs;
    int                  otherErrs;
    int                  pending;
    int                  checked;

    exeDown DUT (
        .clk(clk), .rst(rst),
        .reqValid_i(reqValid), .req_i(req), .fwd_i(fwd),
        .downAllowin_i(downAllowin), .flush_i(flush),
        .allowin_o(allowin), .resValid_o(resValid), .res_o(res)
    );

    exeDownChecker uChecker (
        .clk(clk), .rst(rst),
        .reqValid_i(reqValid), .req_i(req), .fwd_i(fwd),
        .downAllowin_i(downAllowin), .flush_i(flush),
        .allowin_i(allowin), .resValid_i(resValid), .res_i(res),
        .valueErrs_o(valueErrs), .otherErrs_o(otherErrs),
        .pending_o(pending), .checked_o(checked)
    );

    always #2 clk = ~clk;

    //////////////////////////////
    // random source
    //////////////////////////////
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] stepLfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = stepLfsr(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    task automatic makeRequest();
        logic [31:0] w;
        logic [31:0] kind;
        logic [31:0] pick;
        takeBits(5, w);
        req.writeNum = w[4:0];
        takeBits(32, w);
        req.regData0 = w;
        takeBits(32, w);
        req.regData1 = w;
        takeBits(32, w);
        req.imm = w;
        takeBits(32, w);
        req.pc = {w[31:2], 2'b00};
        takeBits(32, w);
        fwd.exeRes = w;
        takeBits(32, w);
        fwd.memRes = w;
        takeBits(2, w);
        req.sel0 = exeDownPkg::fwdSel_e'(w[1:0]);
        takeBits(2, w);
        req.sel1 = exeDownPkg::fwdSel_e'(w[1:0]);
        takeBits(1, w);
        req.ovEnable = w[0];
        takeBits(4, w);
        req.hasExc = (w[3:0] == 4'd0); // rare decode fault
        req.excCode  = req.hasExc ? exeDownPkg::excExt : exeDownPkg::excNone;
        req.memOp    = exeDownPkg::memNone;
        req.trapKind = exeDownPkg::trapNone;
        takeBits(3, kind);
        takeBits(1, pick);
        case (kind[2:0])
            3'd0, 3'd1: begin // load or store at base plus offset
                req.aluOp = exeDownPkg::aluAdd;
                req.sel1  = exeDownPkg::imm;
                takeBits(3, w);
                req.memOp = exeDownPkg::memOp_e'(4'(w[2:0]) + 4'd1);
            end
            3'd2: begin
                takeBits(2, w);
                req.trapKind = exeDownPkg::trapKind_e'(3'(w[1:0]) + 3'd1);
                if (w[1:0] < 2'd2) begin
                    req.aluOp = pick[0] ? exeDownPkg::aluSub : exeDownPkg::aluSubu;
                end else begin
                    req.aluOp = pick[0] ? exeDownPkg::aluSlt : exeDownPkg::aluSltu;
                end
                takeBits(1, w);
                if (w[0]) begin // equal operands
                    req.sel0 = exeDownPkg::regData;
                    req.sel1 = exeDownPkg::regData;
                    req.regData1 = req.regData0;
                end
            end
            3'd3: begin
                req.aluOp = pick[0] ? exeDownPkg::aluClo : exeDownPkg::aluClz;
                req.sel0  = exeDownPkg::regData;
                takeBits(6, w); // shift past 31 clears the word
                req.regData0 = req.regData0 >> w[5:0];
                takeBits(1, w);
                if (w[0]) begin
                    req.regData0 = ~req.regData0;
                end
            end
            default: begin
                takeBits(4, w);
                req.aluOp = exeDownPkg::aluOp_e'(w[3:0]);
            end
        endcase
    endtask

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", CycleLimit);
            $display("Test failures found");
            $finish;
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////
    initial begin
        clk = 1'b0;
        rst = 1'b0;
        lfsr = 32'h93f4_7059;
        reqValid = 1'b0;
        req = '0;
        fwd = '0;
        downAllowin = 1'b1;
        flush = 1'b0;
        accepted = 0;
        repeat (16) @(posedge clk);
        #1 rst = 1'b1;
        while (accepted < NumReqs) begin
            @(posedge clk);
            taken = reqValid && allowin;
            if (taken && !flush) begin
                accepted++;
            end
            #1;
            if (taken) begin
                reqValid = 1'b0; // a request offered under flush is dropped
            end
            if (accepted < NumReqs) begin
                takeBits(2, v);
                downAllowin = (v[1:0] != 2'd0);
                takeBits(8, v);
                flush = (v[7:0] < 8'd6);
                if (!reqValid) begin
                    takeBits(3, v);
                    if (v[2:0] != 3'd0) begin
                        makeRequest();
                        reqValid = 1'b1;
                    end
                end
            end else begin
                reqValid = 1'b0;
                flush = 1'b0;
                downAllowin = 1'b1;
            end
        end
        // let the last op leave the stage
        while (pending != 0) begin
            @(posedge clk);
            #1;
        end
        $display("checked %0d results: %0d value errors, %0d other errors",
                 checked, valueErrs, otherErrs);
        if (valueErrs + otherErrs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+source
source/exeDownPkg.sv
source/stageReg.sv
source/operandForward.sv
source/execAlu.sv
source/memAlign.sv
source/countLeading.sv
source/exeDown.sv
dv/exeDownChecker.sv
dv/exeDownTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = exeDownTb
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	! grep -q "Test failures found" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

.PHONY: simulate clean
